// ==== Makefile ====
SIM  := obj_dir/Vtb_gpio
SRCS := $(wildcard hw/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)

.PHONY: all run clean

all: run

$(SIM): files.f $(SRCS)
	verilator --binary --timing --assert -f files.f --top-module tb_gpio -o Vtb_gpio

# the log decides pass or fail, so a failing run makes grep return non-zero
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Finished with no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/tb_gpio_table.svh ====
`ifndef TB_GPIO_TABLE_SVH
`define TB_GPIO_TABLE_SVH

localparam int NUM_ROWS = 34;

// columns are op, offset, byte select, write data, expected value
// with 8 pins only lane 0 reaches a register, pads rows pack {pd, pu, oeb, o}
localparam row_t ROWS [NUM_ROWS] = '{
    '{OP_PADS,  8'h00,              4'h0, 32'h0000_0000, 32'h0000_ff00},  // reset state
    '{OP_RD,    gpio_pkg::OFF_DATA, 4'h0, 32'h0000_0000, 32'h0000_0000},
    '{OP_RD,    gpio_pkg::OFF_ENA,  4'h0, 32'h0000_0000, 32'h0000_00ff},
    '{OP_RD,    gpio_pkg::OFF_PU,   4'h0, 32'h0000_0000, 32'h0000_0000},
    '{OP_RD,    gpio_pkg::OFF_PD,   4'h0, 32'h0000_0000, 32'h0000_0000},
    '{OP_WR,    gpio_pkg::OFF_DATA, 4'h1, 32'hdead_bea5, 32'h0000_0000},  // upper bits dropped
    '{OP_RD,    gpio_pkg::OFF_DATA, 4'h0, 32'h0000_0000, 32'h0000_00a5},
    '{OP_WR,    gpio_pkg::OFF_DATA, 4'he, 32'h1234_5600, 32'h0000_0000},  // no lane holds a pin
    '{OP_RD,    gpio_pkg::OFF_DATA, 4'h0, 32'h0000_0000, 32'h0000_00a5},
    '{OP_WR,    gpio_pkg::OFF_ENA,  4'h1, 32'hffff_ff0f, 32'h0000_0000},
    '{OP_RD,    gpio_pkg::OFF_ENA,  4'h0, 32'h0000_0000, 32'h0000_000f},
    '{OP_WR,    gpio_pkg::OFF_PU,   4'hf, 32'hffff_ff33, 32'h0000_0000},
    '{OP_WR,    gpio_pkg::OFF_PD,   4'h1, 32'h0000_0055, 32'h0000_0000},
    '{OP_RD,    gpio_pkg::OFF_PU,   4'h0, 32'h0000_0000, 32'h0000_0033},
    '{OP_RD,    gpio_pkg::OFF_PD,   4'h0, 32'h0000_0000, 32'h0000_0055},
    '{OP_PADS,  8'h00,              4'h0, 32'h0000_0000, 32'h0403_0fa5},  // pulls on inputs only
    '{OP_WR,    gpio_pkg::OFF_ENA,  4'h1, 32'h0000_00ff, 32'h0000_0000},
    '{OP_PADS,  8'h00,              4'h0, 32'h0000_0000, 32'h4433_ffa5},  // pull-up wins
    '{OP_WR,    gpio_pkg::OFF_ENA,  4'h1, 32'h0000_00f0, 32'h0000_0000},
    '{OP_EXT,   8'h00,              4'h0, 32'h0000_0000, 32'h0000_0000},
    '{OP_IN,    gpio_pkg::OFF_IN,   4'h0, 32'h0000_0000, 32'h0000_0000},
    '{OP_WR,    gpio_pkg::OFF_DATA, 4'h1, 32'h0000_005a, 32'h0000_0000},
    '{OP_EXT,   8'h00,              4'h0, 32'h0000_0000, 32'h0000_0000},
    '{OP_IN,    gpio_pkg::OFF_IN,   4'h0, 32'h0000_0000, 32'h0000_0000},
    '{OP_WR,    8'h14,              4'hf, 32'hffff_ffff, 32'h0000_0000},  // unmapped offset
    '{OP_RD,    8'h14,              4'h0, 32'h0000_0000, 32'h0000_0000},
    '{OP_WR,    gpio_pkg::OFF_IN,   4'hf, 32'hffff_ffff, 32'h0000_0000},
    '{OP_RD,    gpio_pkg::OFF_DATA, 4'h0, 32'h0000_0000, 32'h0000_005a},
    '{OP_RD,    gpio_pkg::OFF_ENA,  4'h0, 32'h0000_0000, 32'h0000_00f0},
    '{OP_RD,    gpio_pkg::OFF_PU,   4'h0, 32'h0000_0000, 32'h0000_0033},
    '{OP_RD,    gpio_pkg::OFF_PD,   4'h0, 32'h0000_0000, 32'h0000_0055},
    '{OP_RD,    8'hfc,              4'h0, 32'h0000_0000, 32'h0000_0000},
    '{OP_NOACK, gpio_pkg::OFF_DATA, 4'hf, 32'hffff_ffff, 32'h0000_0000},
    '{OP_RD,    gpio_pkg::OFF_DATA, 4'h0, 32'h0000_0000, 32'h0000_005a}   // DATA untouched
};

`endif

// ==== dv/tb_gpio.sv ====
module tb_gpio;

    localparam int          CLK_PERIOD = 40;
    localparam int          PINS       = 8;
    localparam logic [31:0] BASE       = 32'h2100_0000;
    localparam int          ACK_LIMIT  = 8;

    localparam logic [2:0] OP_WR    = 3'd0;
    localparam logic [2:0] OP_RD    = 3'd1;
    localparam logic [2:0] OP_PADS  = 3'd2;   // compares the pad outputs, no bus access
    localparam logic [2:0] OP_EXT   = 3'd3;   // new outside value on undriven pins
    localparam logic [2:0] OP_IN    = 3'd4;
    localparam logic [2:0] OP_NOACK = 3'd5;   // write one page above the base

    typedef struct packed {
        logic [2:0]  op;
        logic [7:0]  off;
        logic [3:0]  sel;
        logic [31:0] wdat;
        logic [31:0] expv;
    } row_t;

    `include "tb_gpio_table.svh"

    logic            clk;
    logic            resetn;
    logic [31:0]     wb_adr;
    logic [31:0]     wb_dat_i;
    logic [3:0]      wb_sel;
    logic            wb_cyc;
    logic            wb_stb;
    logic            wb_we;
    logic [31:0]     wb_dat_o;
    logic            wb_ack;
    logic [PINS-1:0] pad_in;
    logic [PINS-1:0] ext_val;
    logic [PINS-1:0] gpio_o;
    logic [PINS-1:0] gpio_oeb;
    logic [PINS-1:0] gpio_pu;
    logic [PINS-1:0] gpio_pd;
    logic [PINS-1:0] shadow_data;
    logic [PINS-1:0] shadow_ena;
    int              seed;
    int              rnd;
    int              errors;
    int              failed_rows;
    bit              row_ok;

    gpio_top #(
        .NUM_PINS (PINS),
        .BASE_ADR (BASE)
    ) u_gpio_top (
        .clk           (clk),
        .resetn        (resetn),
        .wb_adr_i      (wb_adr),
        .wb_dat_i      (wb_dat_i),
        .wb_sel_i      (wb_sel),
        .wb_cyc_i      (wb_cyc),
        .wb_stb_i      (wb_stb),
        .wb_we_i       (wb_we),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack),
        .gpio_in_pad_i (pad_in),
        .gpio_o        (gpio_o),
        .gpio_oeb_o    (gpio_oeb),
        .gpio_pu_o     (gpio_pu),
        .gpio_pd_o     (gpio_pd)
    );

    // driven pins loop back, the others see the outside world
    assign pad_in = (gpio_o & ~gpio_oeb) | (ext_val & gpio_oeb);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic note_failure();
        errors++;
        row_ok = 1'b0;
    endtask

    task automatic compare(input int row, input string what, input logic [31:0] got,
                           input logic [31:0] expv);
        if (got !== expv) begin
            $display("ERR %0t: row %0d %s got 0x%h, expected 0x%h", $time, row, what, got, expv);
            note_failure();
        end
    endtask

    task automatic bus_transfer(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                                input logic [31:0] wdat, output logic [31:0] rdat,
                                output bit acked);
        int waited;
        waited = 0;
        acked  = 1'b0;
        rdat   = '0;
        @(negedge clk);
        wb_adr   = adr;
        wb_we    = we;
        wb_sel   = sel;
        wb_dat_i = wdat;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        while (!acked && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
            if (wb_ack) begin
                acked = 1'b1;
                rdat  = wb_dat_o;
            end
        end
        if (acked) begin
            @(negedge clk);   // cycle stays open over the edge that ends ack
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    initial begin
        row_t        cur;
        logic [31:0] adr;
        logic [31:0] rdat;
        logic [31:0] exp_in;
        bit          acked;
        seed        = 65;
        errors      = 0;
        failed_rows = 0;
        resetn      = 1'b0;
        wb_adr      = '0;
        wb_dat_i    = '0;
        wb_sel      = '0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        ext_val     = '0;
        shadow_data = '0;
        shadow_ena  = '1;   // every pin comes out of reset as an input
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        for (int i = 0; i < NUM_ROWS; i++) begin
            cur    = ROWS[i];
            row_ok = 1'b1;
            adr    = {BASE[31:8], cur.off};
            case (cur.op)
                OP_WR, OP_RD, OP_IN: begin
                    bus_transfer(cur.op == OP_WR, adr, cur.sel, cur.wdat, rdat, acked);
                    if (!acked) begin
                        $display("row %0d: no acknowledge within %0d cycles", i, ACK_LIMIT);
                        note_failure();
                    end else if (cur.op == OP_RD) begin
                        compare(i, "read", rdat, cur.expv);
                    end else if (cur.op == OP_IN) begin
                        exp_in = '0;
                        exp_in[PINS-1:0] = (shadow_data & ~shadow_ena) | (ext_val & shadow_ena);
                        compare(i, "IN read", rdat, exp_in);
                    end
                    if (cur.op == OP_WR && cur.sel[0] && cur.off == gpio_pkg::OFF_DATA) begin
                        shadow_data = cur.wdat[PINS-1:0];
                    end
                    if (cur.op == OP_WR && cur.sel[0] && cur.off == gpio_pkg::OFF_ENA) begin
                        shadow_ena = cur.wdat[PINS-1:0];
                    end
                end
                OP_PADS: begin
                    @(negedge clk);
                    compare(i, "pads", {gpio_pd, gpio_pu, gpio_oeb, gpio_o}, cur.expv);
                end
                OP_EXT: begin
                    @(negedge clk);
                    rnd     = $random(seed);
                    ext_val = rnd[PINS-1:0];
                    repeat (3) @(negedge clk);   // two synchronizer flops plus margin
                end
                OP_NOACK: begin
                    adr = {BASE[31:8] + 24'h1, cur.off};
                    bus_transfer(1'b1, adr, cur.sel, cur.wdat, rdat, acked);
                    if (acked) begin
                        $display("row %0d: request outside the page was acknowledged", i);
                        note_failure();
                    end else begin
                        $display("row %0d: request outside the page got no acknowledge", i);
                    end
                end
                default: begin
                    $display("row %0d: the table holds an unknown operation", i);
                    note_failure();
                end
            endcase
            if (row_ok) begin
                $display("row %0d op %0d off 0x%h: ok", i, cur.op, cur.off);
            end else begin
                $display("row %0d op %0d off 0x%h: failed", i, cur.op, cur.off);
                failed_rows++;
            end
        end

        $display("rows run: %0d, rows failed: %0d, errors: %0d", NUM_ROWS, failed_rows, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #((NUM_ROWS + 40) * 20 * CLK_PERIOD);
        $display("timeout: the table did not finish within %0d cycles", (NUM_ROWS + 40) * 20);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+dv
hw/gpio_pkg.sv
hw/gpio_bus_port.sv
hw/gpio_regs.sv
hw/gpio_pad_stage.sv
hw/gpio_top.sv
dv/tb_gpio.sv

// ==== hw/gpio_bus_port.sv ====
module gpio_bus_port #(
    parameter logic [31:0] BASE_ADR = 32'h2100_0000
) (
    input  logic                          clk,
    input  logic                          resetn,

    input  logic [gpio_pkg::ADDR_W-1:0]   wb_adr_i,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    output logic                          wb_ack_o,

    output logic                          acc_o,
    output logic                          we_o,
    output gpio_pkg::gpio_reg_e           reg_o
);

    logic page_hit;
    logic req;
    logic ack_q;

    // only the page number takes part in the match
    assign page_hit = (wb_adr_i[gpio_pkg::ADDR_W-1:8] == BASE_ADR[gpio_pkg::ADDR_W-1:8]);
    assign req      = wb_cyc_i && wb_stb_i;

    // the cycle after an ack is never an accept, so a held strobe gets one transfer per two cycles
    assign acc_o = req && page_hit && !ack_q;
    assign we_o  = wb_we_i;    // qualified by acc_o in the register block

    always_comb begin
        case (wb_adr_i[7:0])
            gpio_pkg::OFF_DATA: reg_o = gpio_pkg::REG_DATA;
            gpio_pkg::OFF_ENA:  reg_o = gpio_pkg::REG_ENA;
            gpio_pkg::OFF_PU:   reg_o = gpio_pkg::REG_PU;
            gpio_pkg::OFF_PD:   reg_o = gpio_pkg::REG_PD;
            gpio_pkg::OFF_IN:   reg_o = gpio_pkg::REG_IN;
            default:            reg_o = gpio_pkg::REG_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= acc_o;    // one cycle after the accept edge
        end
    end

    assign wb_ack_o = ack_q;

    // a single accepted request never produces a second ack
    a_ack_single : assert property (
        @(posedge clk) disable iff (!resetn)
        wb_ack_o |=> !wb_ack_o
    );

    // an accept is answered while the master still holds its cycle open
    a_acc_answered : assert property (
        @(posedge clk) disable iff (!resetn)
        acc_o |-> wb_cyc_i ##1 (wb_ack_o && wb_cyc_i)
    );

endmodule

// ==== hw/gpio_pad_stage.sv ====
module gpio_pad_stage #(
    parameter int NUM_PINS = 8
) (
    input  logic                  clk,
    input  logic                  resetn,

    input  logic [NUM_PINS-1:0]   pad_i,
    input  logic [NUM_PINS-1:0]   data_i,
    input  logic [NUM_PINS-1:0]   ena_i,
    input  logic [NUM_PINS-1:0]   pu_i,
    input  logic [NUM_PINS-1:0]   pd_i,

    output logic [NUM_PINS-1:0]   in_sync_o,
    output logic [NUM_PINS-1:0]   gpio_o,
    output logic [NUM_PINS-1:0]   gpio_oeb_o,
    output logic [NUM_PINS-1:0]   gpio_pu_o,
    output logic [NUM_PINS-1:0]   gpio_pd_o
);

    logic [NUM_PINS-1:0] meta_q;
    logic [NUM_PINS-1:0] sync_q;
    logic [NUM_PINS-1:0] in_mode;

    // pads change with no relation to clk
    always_ff @(posedge clk) begin
        if (!resetn) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= pad_i;
            sync_q <= meta_q;
        end
    end

    assign in_sync_o = sync_q;

    // an enable bit of one leaves the pin undriven
    assign in_mode = ena_i;

    assign gpio_o     = data_i;
    assign gpio_oeb_o = ena_i;

    // pulls only act on input pins, and the pull-up wins
    assign gpio_pu_o = pu_i & in_mode;
    assign gpio_pd_o = pd_i & in_mode & ~pu_i;

    // both pulls on one pin would short the pad bias network
    a_pull_exclusive : assert property (
        @(posedge clk) disable iff (!resetn)
        (gpio_pu_o & gpio_pd_o) == '0
    );

endmodule

// ==== hw/gpio_pkg.sv ====
package gpio_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = 4;      // one select bit per byte lane

    // register offsets inside the 256-byte page
    localparam logic [7:0] OFF_DATA = 8'h00;
    localparam logic [7:0] OFF_ENA  = 8'h04;
    localparam logic [7:0] OFF_PU   = 8'h08;
    localparam logic [7:0] OFF_PD   = 8'h0c;
    localparam logic [7:0] OFF_IN   = 8'h10;

    typedef enum logic [2:0] {
        REG_DATA = 3'd0,
        REG_ENA  = 3'd1,
        REG_PU   = 3'd2,
        REG_PD   = 3'd3,
        REG_IN   = 3'd4,
        REG_NONE = 3'd5             // any other offset inside the page
    } gpio_reg_e;

    // full width reset values, trimmed to the pin count where used
    localparam logic [31:0] RST_DATA = 32'h0000_0000;
    localparam logic [31:0] RST_ENA  = 32'hffff_ffff;  // all pins start as inputs
    localparam logic [31:0] RST_PU   = 32'h0000_0000;
    localparam logic [31:0] RST_PD   = 32'h0000_0000;

endpackage

// ==== hw/gpio_regs.sv ====
module gpio_regs #(
    parameter int NUM_PINS = 8
) (
    input  logic                          clk,
    input  logic                          resetn,

    input  logic                          acc_i,
    input  logic                          we_i,
    input  gpio_pkg::gpio_reg_e           reg_i,
    input  logic [gpio_pkg::SEL_W-1:0]    sel_i,
    input  logic [gpio_pkg::DATA_W-1:0]   wdata_i,
    input  logic [NUM_PINS-1:0]           in_sync_i,

    output logic [gpio_pkg::DATA_W-1:0]   rdata_o,
    output logic [NUM_PINS-1:0]           data_o,
    output logic [NUM_PINS-1:0]           ena_o,
    output logic [NUM_PINS-1:0]           pu_o,
    output logic [NUM_PINS-1:0]           pd_o
);

    if (NUM_PINS < 1 || NUM_PINS > 32) begin : g_pin_check
        $error("gpio_regs supports 1 to 32 pins");
    end

    logic [NUM_PINS-1:0]         data_q;
    logic [NUM_PINS-1:0]         ena_q;
    logic [NUM_PINS-1:0]         pu_q;
    logic [NUM_PINS-1:0]         pd_q;
    logic [gpio_pkg::DATA_W-1:0] rd_val;
    logic [gpio_pkg::DATA_W-1:0] rdata_q;
    logic                        wr;

    // each pin bit belongs to the byte lane it sits in
    function automatic logic [NUM_PINS-1:0] lane_merge(
        input logic [NUM_PINS-1:0]         old_v,
        input logic [gpio_pkg::DATA_W-1:0] new_v,
        input logic [gpio_pkg::SEL_W-1:0]  sel
    );
        logic [NUM_PINS-1:0] res;
        res = old_v;
        for (int i = 0; i < NUM_PINS; i++) begin
            if (sel[i / 8]) begin
                res[i] = new_v[i];
            end
        end
        return res;
    endfunction

    assign wr = acc_i && we_i;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            data_q <= gpio_pkg::RST_DATA[NUM_PINS-1:0];
            ena_q  <= gpio_pkg::RST_ENA[NUM_PINS-1:0];
            pu_q   <= gpio_pkg::RST_PU[NUM_PINS-1:0];
            pd_q   <= gpio_pkg::RST_PD[NUM_PINS-1:0];
        end else if (wr) begin
            case (reg_i)
                gpio_pkg::REG_DATA: begin
                    data_q <= lane_merge(data_q, wdata_i, sel_i);
                end
                gpio_pkg::REG_ENA: begin
                    ena_q <= lane_merge(ena_q, wdata_i, sel_i);
                end
                gpio_pkg::REG_PU: begin
                    pu_q <= lane_merge(pu_q, wdata_i, sel_i);
                end
                gpio_pkg::REG_PD: begin
                    pd_q <= lane_merge(pd_q, wdata_i, sel_i);
                end
                default: begin
                    // IN is read only and unmapped offsets hold nothing
                end
            endcase
        end
    end

    // bits at and above the pin count stay zero
    always_comb begin
        rd_val = '0;
        case (reg_i)
            gpio_pkg::REG_DATA: rd_val[NUM_PINS-1:0] = data_q;
            gpio_pkg::REG_ENA:  rd_val[NUM_PINS-1:0] = ena_q;
            gpio_pkg::REG_PU:   rd_val[NUM_PINS-1:0] = pu_q;
            gpio_pkg::REG_PD:   rd_val[NUM_PINS-1:0] = pd_q;
            gpio_pkg::REG_IN:   rd_val[NUM_PINS-1:0] = in_sync_i;
            default:            rd_val = '0;
        endcase
    end

    // captured on the accept edge so it is valid during ack
    always_ff @(posedge clk) begin
        if (acc_i) begin
            rdata_q <= rd_val;    // the old value on a write, like a read-before-write
        end
    end

    assign rdata_o = rdata_q;
    assign data_o  = data_q;
    assign ena_o   = ena_q;
    assign pu_o    = pu_q;
    assign pd_o    = pd_q;

    // the index comes from the bus port decode and must be settled on an accept
    a_reg_known : assert property (
        @(posedge clk) disable iff (!resetn)
        acc_i |-> !$isunknown(reg_i)
    );

endmodule

// ==== hw/gpio_top.sv ====
module gpio_top #(
    parameter int          NUM_PINS = 8,
    parameter logic [31:0] BASE_ADR = 32'h2100_0000
) (
    input  logic                          clk,
    input  logic                          resetn,

    input  logic [gpio_pkg::ADDR_W-1:0]   wb_adr_i,
    input  logic [gpio_pkg::DATA_W-1:0]   wb_dat_i,
    input  logic [gpio_pkg::SEL_W-1:0]    wb_sel_i,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    output logic [gpio_pkg::DATA_W-1:0]   wb_dat_o,
    output logic                          wb_ack_o,

    input  logic [NUM_PINS-1:0]           gpio_in_pad_i,
    output logic [NUM_PINS-1:0]           gpio_o,
    output logic [NUM_PINS-1:0]           gpio_oeb_o,
    output logic [NUM_PINS-1:0]           gpio_pu_o,
    output logic [NUM_PINS-1:0]           gpio_pd_o
);

    logic                acc;
    logic                we;
    gpio_pkg::gpio_reg_e reg_idx;
    logic [NUM_PINS-1:0] data_q;
    logic [NUM_PINS-1:0] ena_q;
    logic [NUM_PINS-1:0] pu_q;
    logic [NUM_PINS-1:0] pd_q;
    logic [NUM_PINS-1:0] in_sync;

    gpio_bus_port #(
        .BASE_ADR (BASE_ADR)
    ) u_bus_port (
        .clk      (clk),
        .resetn   (resetn),
        .wb_adr_i (wb_adr_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_ack_o (wb_ack_o),
        .acc_o    (acc),
        .we_o     (we),
        .reg_o    (reg_idx)
    );

    gpio_regs #(
        .NUM_PINS (NUM_PINS)
    ) u_regs (
        .clk       (clk),
        .resetn    (resetn),
        .acc_i     (acc),
        .we_i      (we),
        .reg_i     (reg_idx),
        .sel_i     (wb_sel_i),
        .wdata_i   (wb_dat_i),
        .in_sync_i (in_sync),
        .rdata_o   (wb_dat_o),
        .data_o    (data_q),
        .ena_o     (ena_q),
        .pu_o      (pu_q),
        .pd_o      (pd_q)
    );

    gpio_pad_stage #(
        .NUM_PINS (NUM_PINS)
    ) u_pad_stage (
        .clk        (clk),
        .resetn     (resetn),
        .pad_i      (gpio_in_pad_i),
        .data_i     (data_q),
        .ena_i      (ena_q),
        .pu_i       (pu_q),
        .pd_i       (pd_q),
        .in_sync_o  (in_sync),
        .gpio_o     (gpio_o),
        .gpio_oeb_o (gpio_oeb_o),
        .gpio_pu_o  (gpio_pu_o),
        .gpio_pd_o  (gpio_pd_o)
    );

endmodule
